/* logic/miniCorePkg.sv */
`default_nettype none

package miniCorePkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int regCount     = 32;

    localparam logic [dataWidth-1:0] resetPc  = '0;
    localparam logic [dataWidth-1:0] pcStep   = 4;
    localparam logic [dataWidth-1:0] nopInstr = '0;     // sll $0,$0,0

    localparam logic [regAddrWidth-1:0] zeroReg = '0;

    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opJ       = 6'h02,
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opAddiu   = 6'h09,
        opLui     = 6'h0f
    } opcodeT;

    // function field of special instructions
    typedef enum logic [5:0] {
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnSlt  = 6'h2a
    } functT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluLui
    } aluOpT;

    typedef enum logic [1:0] {
        ctrlNone,
        ctrlBeq,
        ctrlBne,
        ctrlJump
    } ctrlKindT;

endpackage

`default_nettype wire

/* logic/pipeBus.sv */
`timescale 1ns/1ps
`default_nettype none

// decode -> execute slot
interface decExBus;
    logic                                   valid;
    logic [miniCorePkg::dataWidth-1:0]      pc;
    miniCorePkg::aluOpT                     aluOp;
    miniCorePkg::ctrlKindT                  ctrlKind;
    logic                                   useImm;
    logic [miniCorePkg::regAddrWidth-1:0]   rsNum;
    logic [miniCorePkg::regAddrWidth-1:0]   rtNum;
    logic [miniCorePkg::dataWidth-1:0]      rsValue;
    logic [miniCorePkg::dataWidth-1:0]      rtValue;
    logic [miniCorePkg::dataWidth-1:0]      imm;
    logic [miniCorePkg::dataWidth-1:0]      target;     // branch or jump destination
    logic [miniCorePkg::regAddrWidth-1:0]   dest;
    logic                                   writeEn;

    modport producer (output valid, pc, aluOp, ctrlKind, useImm, rsNum, rtNum,
                      rsValue, rtValue, imm, target, dest, writeEn);
    modport consumer (input valid, pc, aluOp, ctrlKind, useImm, rsNum, rtNum,
                      rsValue, rtValue, imm, target, dest, writeEn);
endinterface

// execute -> writeback register
interface exWbBus;
    logic                                   valid;
    logic [miniCorePkg::dataWidth-1:0]      pc;
    logic [miniCorePkg::regAddrWidth-1:0]   dest;
    logic                                   writeEn;
    logic [miniCorePkg::dataWidth-1:0]      result;

    modport producer (output valid, pc, dest, writeEn, result);
    modport regPort  (input valid, dest, writeEn, result);     // register file write
    modport bypass   (input valid, dest, writeEn, result);
endinterface

`default_nettype wire

/* logic/fetchUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchUnit (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire  [miniCorePkg::dataWidth-1:0]   instrF,
    input  wire                                 iCacheStall,
    input  wire                                 redirect,
    input  wire  [miniCorePkg::dataWidth-1:0]   redirectPc,
    output logic [miniCorePkg::dataWidth-1:0]   pcF,
    output logic                                instEn,
    output logic [miniCorePkg::dataWidth-1:0]   instrD,
    output logic [miniCorePkg::dataWidth-1:0]   pcD,
    output logic                                validD
);

    logic [miniCorePkg::dataWidth-1:0] pcNext;
    logic bubble;

    assign bubble = iCacheStall || redirect;

    // redirect wins over a stall so the target is never lost
    always_comb begin
        if (redirect) begin
            pcNext = redirectPc;
        end else if (iCacheStall) begin
            pcNext = pcF;
        end else begin
            pcNext = pcF + miniCorePkg::pcStep;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pcF <= miniCorePkg::resetPc;
        end else begin
            pcF <= pcNext;
        end
    end

    assign instEn = !redirect;  // wrong-path word is thrown away

    always_ff @(posedge clk) begin
        if (reset) begin
            validD <= 1'b0;
        end else begin
            validD <= !bubble;
        end
    end

    always_ff @(posedge clk) begin
        pcD    <= pcF;
        instrD <= bubble ? miniCorePkg::nopInstr : instrF;
    end

    pcAligned: assert property (@(posedge clk) disable iff (reset) pcF[1:0] == 2'b00);

endmodule

`default_nettype wire

/* logic/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire                                 clk,
    input  wire  [miniCorePkg::regAddrWidth-1:0] readNumA,
    input  wire  [miniCorePkg::regAddrWidth-1:0] readNumB,
    exWbBus.regPort                             wb,
    output logic [miniCorePkg::dataWidth-1:0]   readDataA,
    output logic [miniCorePkg::dataWidth-1:0]   readDataB
);

    logic [miniCorePkg::dataWidth-1:0] regs [1:miniCorePkg::regCount-1];  // $0 not stored
    logic writing;

    assign writing = wb.valid && wb.writeEn;

    always_ff @(posedge clk) begin
        if (writing) begin
            regs[wb.dest] <= wb.result;
        end
    end

    // same-cycle write passes straight through
    assign readDataA = (readNumA == miniCorePkg::zeroReg) ? '0 :
                       (writing && wb.dest == readNumA) ? wb.result : regs[readNumA];
    assign readDataB = (readNumB == miniCorePkg::zeroReg) ? '0 :
                       (writing && wb.dest == readNumB) ? wb.result : regs[readNumB];

    noZeroWrite: assert property (@(posedge clk)
        wb.valid && wb.writeEn |-> wb.dest != miniCorePkg::zeroReg);

endmodule

`default_nettype wire

/* logic/decodeUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeUnit (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire  [miniCorePkg::dataWidth-1:0]   instrD,
    input  wire  [miniCorePkg::dataWidth-1:0]   pcD,
    input  wire                                 validD,
    input  wire                                 redirect,
    input  wire  [miniCorePkg::dataWidth-1:0]   readDataA,
    input  wire  [miniCorePkg::dataWidth-1:0]   readDataB,
    output logic [miniCorePkg::regAddrWidth-1:0] readNumA,
    output logic [miniCorePkg::regAddrWidth-1:0] readNumB,
    decExBus.producer                           dx
);

    miniCorePkg::opcodeT   opcode;
    miniCorePkg::functT    funct;
    miniCorePkg::aluOpT    aluOp;
    miniCorePkg::ctrlKindT ctrlKind;
    logic useImm;
    logic signExt;
    logic writeEn;
    logic [miniCorePkg::regAddrWidth-1:0] dest;
    logic [miniCorePkg::dataWidth-1:0] immExt;
    logic [miniCorePkg::dataWidth-1:0] pcPlus4;
    logic [miniCorePkg::dataWidth-1:0] target;

    assign opcode   = miniCorePkg::opcodeT'(instrD[31:26]);
    assign funct    = miniCorePkg::functT'(instrD[5:0]);
    assign readNumA = instrD[25:21];
    assign readNumB = instrD[20:16];

    always_comb begin
        aluOp    = miniCorePkg::aluAdd;
        ctrlKind = miniCorePkg::ctrlNone;
        useImm   = 1'b0;
        signExt  = 1'b0;
        writeEn  = 1'b0;
        dest     = instrD[20:16];  // rt unless R-type
        case (opcode)
            miniCorePkg::opSpecial: begin
                dest    = instrD[15:11];
                writeEn = 1'b1;
                case (funct)
                    miniCorePkg::fnAddu: aluOp = miniCorePkg::aluAdd;
                    miniCorePkg::fnSubu: aluOp = miniCorePkg::aluSub;
                    miniCorePkg::fnAnd:  aluOp = miniCorePkg::aluAnd;
                    miniCorePkg::fnOr:   aluOp = miniCorePkg::aluOr;
                    miniCorePkg::fnSlt:  aluOp = miniCorePkg::aluSlt;
                    default:             writeEn = 1'b0;  // includes the nop word
                endcase
            end
            miniCorePkg::opAddiu: begin
                useImm  = 1'b1;
                signExt = 1'b1;
                writeEn = 1'b1;
            end
            miniCorePkg::opLui: begin
                aluOp   = miniCorePkg::aluLui;
                useImm  = 1'b1;
                writeEn = 1'b1;
            end
            miniCorePkg::opBeq: begin
                ctrlKind = miniCorePkg::ctrlBeq;
                signExt  = 1'b1;
            end
            miniCorePkg::opBne: begin
                ctrlKind = miniCorePkg::ctrlBne;
                signExt  = 1'b1;
            end
            miniCorePkg::opJ: ctrlKind = miniCorePkg::ctrlJump;
            default: ;
        endcase
    end

    assign immExt  = signExt ? {{16{instrD[15]}}, instrD[15:0]} : {16'b0, instrD[15:0]};
    assign pcPlus4 = pcD + miniCorePkg::pcStep;
    assign target  = (ctrlKind == miniCorePkg::ctrlJump) ?
                     {pcPlus4[31:28], instrD[25:0], 2'b00} : pcPlus4 + (immExt << 2);

    always_ff @(posedge clk) begin
        if (reset || redirect) begin
            dx.valid <= 1'b0;  // younger than the taken transfer
        end else begin
            dx.valid <= validD;
        end
    end

    always_ff @(posedge clk) begin
        dx.pc       <= pcD;
        dx.aluOp    <= aluOp;
        dx.ctrlKind <= ctrlKind;
        dx.useImm   <= useImm;
        dx.rsNum    <= readNumA;
        dx.rtNum    <= readNumB;
        dx.rsValue  <= readDataA;
        dx.rtValue  <= readDataB;
        dx.imm      <= immExt;
        dx.target   <= target;
        dx.dest     <= dest;
        dx.writeEn  <= writeEn && dest != miniCorePkg::zeroReg;
    end

    ctrlKnown: assert property (@(posedge clk) disable iff (reset)
        dx.valid |-> !$isunknown(dx.ctrlKind));

endmodule

`default_nettype wire

/* logic/executeUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module executeUnit (
    input  wire                                 clk,
    input  wire                                 reset,
    decExBus.consumer                           dx,
    exWbBus.producer                            xw,
    output logic                                redirect,
    output logic [miniCorePkg::dataWidth-1:0]   redirectPc
);

    logic [miniCorePkg::dataWidth-1:0] rsVal;
    logic [miniCorePkg::dataWidth-1:0] rtVal;
    logic [miniCorePkg::dataWidth-1:0] srcB;
    logic [miniCorePkg::dataWidth-1:0] result;
    logic wbWriting;
    logic lessThan;
    logic taken;

    // bypass from the writeback register
    assign wbWriting = xw.valid && xw.writeEn;
    assign rsVal = (wbWriting && xw.dest == dx.rsNum) ? xw.result : dx.rsValue;
    assign rtVal = (wbWriting && xw.dest == dx.rtNum) ? xw.result : dx.rtValue;

    assign srcB     = dx.useImm ? dx.imm : rtVal;
    assign lessThan = $signed(rsVal) < $signed(srcB);

    always_comb begin
        case (dx.aluOp)
            miniCorePkg::aluAdd: result = rsVal + srcB;
            miniCorePkg::aluSub: result = rsVal - srcB;
            miniCorePkg::aluAnd: result = rsVal & srcB;
            miniCorePkg::aluOr:  result = rsVal | srcB;
            miniCorePkg::aluSlt: result = {{(miniCorePkg::dataWidth-1){1'b0}}, lessThan};
            miniCorePkg::aluLui: result = srcB << 16;
            default:             result = '0;
        endcase
    end

    always_comb begin
        case (dx.ctrlKind)
            miniCorePkg::ctrlBeq:  taken = rsVal == rtVal;
            miniCorePkg::ctrlBne:  taken = rsVal != rtVal;
            miniCorePkg::ctrlJump: taken = 1'b1;
            default:               taken = 1'b0;
        endcase
    end

    // not-taken was predicted, so any taken transfer redirects
    assign redirect   = dx.valid && taken;
    assign redirectPc = dx.target;

    always_ff @(posedge clk) begin
        if (reset) begin
            xw.valid <= 1'b0;
        end else begin
            xw.valid <= dx.valid;  // the branch itself stays valid
        end
    end

    always_ff @(posedge clk) begin
        xw.pc      <= dx.pc;
        xw.dest    <= dx.dest;
        xw.writeEn <= dx.writeEn;
        xw.result  <= result;
    end

endmodule

`default_nettype wire

/* logic/miniCore.sv */
`timescale 1ns/1ps
`default_nettype none

module miniCore (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire  [miniCorePkg::dataWidth-1:0]   instrF,
    input  wire                                 iCacheStall,
    output logic [miniCorePkg::dataWidth-1:0]   pcF,
    output logic                                instEn,
    output logic [miniCorePkg::dataWidth-1:0]   debugWbPc,
    output logic [3:0]                          debugWbRfWen,
    output logic [miniCorePkg::regAddrWidth-1:0] debugWbRfWnum,
    output logic [miniCorePkg::dataWidth-1:0]   debugWbRfWdata
);

    logic [miniCorePkg::dataWidth-1:0]    instrD;
    logic [miniCorePkg::dataWidth-1:0]    pcD;
    logic                                 validD;
    logic                                 redirect;
    logic [miniCorePkg::dataWidth-1:0]    redirectPc;
    logic [miniCorePkg::regAddrWidth-1:0] readNumA;
    logic [miniCorePkg::regAddrWidth-1:0] readNumB;
    logic [miniCorePkg::dataWidth-1:0]    readDataA;
    logic [miniCorePkg::dataWidth-1:0]    readDataB;

    decExBus dxBus ();
    exWbBus  xwBus ();

    fetchUnit fetchUnit0 (
        .clk(clk), .reset(reset),
        .instrF(instrF),
        .iCacheStall(iCacheStall),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .pcF(pcF),
        .instEn(instEn),
        .instrD(instrD), .pcD(pcD), .validD(validD)
    );

    decodeUnit decodeUnit0 (
        .clk(clk), .reset(reset),
        .instrD(instrD), .pcD(pcD), .validD(validD),
        .redirect(redirect),
        .readDataA(readDataA), .readDataB(readDataB),
        .readNumA(readNumA), .readNumB(readNumB),
        .dx(dxBus)
    );

    regFile regFile0 (
        .clk(clk),
        .readNumA(readNumA), .readNumB(readNumB),
        .wb(xwBus),
        .readDataA(readDataA), .readDataB(readDataB)
    );

    executeUnit executeUnit0 (
        .clk(clk), .reset(reset),
        .dx(dxBus),
        .xw(xwBus),
        .redirect(redirect),
        .redirectPc(redirectPc)
    );

    // debug trace straight off the writeback register
    assign debugWbPc      = xwBus.pc;
    assign debugWbRfWen   = {4{xwBus.valid & xwBus.writeEn}};
    assign debugWbRfWnum  = xwBus.dest;
    assign debugWbRfWdata = xwBus.result;

endmodule

`default_nettype wire

/* sim/wbChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module wbChecker (
    input wire        clk,
    input wire        reset,
    input wire        instEn,
    input wire [31:0] debugWbPc,
    input wire [3:0]  debugWbRfWen,
    input wire [4:0]  debugWbRfWnum,
    input wire [31:0] debugWbRfWdata
);

    logic [31:0] expPc   [$];
    logic [4:0]  expNum  [$];
    logic [31:0] expData [$];

    int errorCount;
    int checkedCount;
    int quietCycles;   // cycles since the last writeback
    logic resetSeen;   // reset as sampled at the last rising edge

    initial begin
        errorCount   = 0;
        checkedCount = 0;
        quietCycles  = 0;
    end

    task automatic expectWrite(input logic [31:0] pc, input logic [4:0] num,
                               input logic [31:0] data);
        expPc.push_back(pc);
        expNum.push_back(num);
        expData.push_back(data);
    endtask

    function automatic int pending();
        return expPc.size();
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] want, input logic [31:0] pc);
        if (got !== want) begin
            $display("[ERROR] %s: got %h, expected %h (pc %h)", name, got, want, pc);
            errorCount++;
        end
    endtask

    task automatic compareWrite();
        logic [31:0] pc;
        logic [4:0]  num;
        logic [31:0] data;
        if (expPc.size() == 0) begin
            $display("unexpected writeback to register %0d from pc %h after the trace ended",
                     debugWbRfWnum, debugWbPc);
            errorCount++;
        end else begin
            pc   = expPc.pop_front();
            num  = expNum.pop_front();
            data = expData.pop_front();
            checkValue("debugWbRfWen", {28'b0, debugWbRfWen}, 32'hf, pc);
            checkValue("debugWbPc", debugWbPc, pc, pc);
            checkValue("debugWbRfWnum", {27'b0, debugWbRfWnum}, {27'b0, num}, pc);
            checkValue("debugWbRfWdata", debugWbRfWdata, data, pc);
            checkedCount++;
        end
    endtask

    always @(posedge clk) begin
        resetSeen <= reset;
    end

    // state left by a reset edge
    task automatic checkResetState();
        if (instEn !== 1'b1) begin
            $display("[ERROR] instEn after reset: got %h, expected 1", instEn);
            errorCount++;
        end
        if (debugWbRfWen !== 4'h0) begin
            $display("[ERROR] debugWbRfWen after reset: got %h, expected 0", debugWbRfWen);
            errorCount++;
        end
    endtask

    // writeback register settles well before the falling edge
    always @(negedge clk) begin
        if (resetSeen === 1'b1) begin
            checkResetState();
        end
        if (reset !== 1'b0) begin
            quietCycles = 0;
        end else if (debugWbRfWen !== 4'h0) begin
            quietCycles = 0;
            compareWrite();
        end else begin
            quietCycles++;
        end
    end

endmodule

`default_nettype wire

/* sim/miniCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module miniCoreTb;

    localparam int stimDepth  = 256;
    localparam int progDepth  = 64;
    localparam int quietLimit = 20;

    logic        clk;
    logic        reset;
    logic [31:0] instrF;
    logic        iCacheStall;
    logic [31:0] pcF;
    logic        instEn;
    logic [31:0] debugWbPc;
    logic [3:0]  debugWbRfWen;
    logic [4:0]  debugWbRfWnum;
    logic [31:0] debugWbRfWdata;

    logic [31:0] stimWords [0:stimDepth-1];
    logic [31:0] progMem [0:progDepth-1];
    int          progLen;
    logic        stallMode;
    logic [31:0] lcgState;
    int          cycleCount;
    int          cycleLimit;
    logic        limitReady;

    miniCore dut (
        .clk(clk), .reset(reset),
        .instrF(instrF),
        .iCacheStall(iCacheStall),
        .pcF(pcF),
        .instEn(instEn),
        .debugWbPc(debugWbPc),
        .debugWbRfWen(debugWbRfWen),
        .debugWbRfWnum(debugWbRfWnum),
        .debugWbRfWdata(debugWbRfWdata)
    );

    wbChecker wbCheck (
        .clk(clk), .reset(reset),
        .instEn(instEn),
        .debugWbPc(debugWbPc),
        .debugWbRfWen(debugWbRfWen),
        .debugWbRfWnum(debugWbRfWnum),
        .debugWbRfWdata(debugWbRfWdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // past the end of the program every word is a jump to itself
    function automatic logic [31:0] fetchWord(input logic [31:0] addr);
        int idx;
        idx = addr[31:2];
        if (idx < progLen) begin
            return progMem[idx];
        end
        return 32'h0800_0000 | {6'b0, addr[27:2]};
    endfunction

    task automatic loadTest(input int start, output int next, output int expCount);
        int idx;
        progLen  = stimWords[start];
        expCount = stimWords[start + 1];
        idx      = start + 2;
        for (int i = 0; i < progLen; i++) begin
            progMem[i] = stimWords[idx];
            idx++;
        end
        for (int i = 0; i < expCount; i++) begin
            wbCheck.expectWrite(stimWords[idx], stimWords[idx + 1][4:0], stimWords[idx + 2]);
            idx += 3;
        end
        next = idx;
    endtask

    initial begin
        instrF      = '0;
        iCacheStall = 1'b0;
        lcgState    = 32'd41815;
        forever begin
            @(posedge clk);
            #1;
            instrF      = fetchWord(pcF);
            lcgState    = lcgNext(lcgState);
            iCacheStall = stallMode && (lcgState[31:30] == 2'b00);  // about one in four
        end
    end

    initial begin
        cycleCount = 0;
        wait (limitReady);
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout after %0d cycles, the writeback trace was not completed", cycleCount);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : mainFlow
        int ptr;
        int progCount;
        int totalLen;
        int expCount;
        int errBefore;
        int checkedBefore;
        int errs;
        int testNum;
        int passCount;
        int failCount;
        string modeName;

        reset      = 1'b1;
        stallMode  = 1'b0;
        limitReady = 1'b0;
        progLen    = 0;
        testNum    = 0;
        passCount  = 0;
        failCount  = 0;
        $readmemh("sim/miniCoreStim.txt", stimWords);
        progCount = stimWords[0];

        ptr      = 1;
        totalLen = 0;
        for (int p = 0; p < progCount; p++) begin
            totalLen += stimWords[ptr];
            ptr += 2 + stimWords[ptr] + 3 * stimWords[ptr + 1];
        end
        cycleLimit = 2 * (20 * totalLen + 100 * progCount);  // each program runs twice
        limitReady = 1'b1;

        for (int round = 0; round < 2; round++) begin
            ptr = 1;
            for (int p = 0; p < progCount; p++) begin
                @(posedge clk);
                #1;
                reset         = 1'b1;
                stallMode     = (round == 1);
                errBefore     = wbCheck.errorCount;
                checkedBefore = wbCheck.checkedCount;
                loadTest(ptr, ptr, expCount);
                repeat (8) @(posedge clk);
                #1;
                reset = 1'b0;

                while (wbCheck.pending() != 0 || wbCheck.quietCycles < quietLimit) begin
                    @(posedge clk);
                end

                testNum++;
                errs     = wbCheck.errorCount - errBefore;
                modeName = stallMode ? "random stalls" : "no stalls";
                if (errs == 0) begin
                    passCount++;
                end else begin
                    failCount++;
                end
                $display("test %0d, program %0d, %s: %0d of %0d writebacks checked, %0d errors, %s",
                         testNum, p + 1, modeName, wbCheck.checkedCount - checkedBefore,
                         expCount, errs, (errs == 0) ? "pass" : "fail");
            end
        end

        $display("tests run %0d, passed %0d, failed %0d", testNum, passCount, failCount);
        if (failCount == 0 && wbCheck.errorCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/miniCoreStim.txt */
// test count, then per test: program length and trace length (hex),
// the program words, then pc / register / data for each expected writeback
4

// dependent alu chain: addiu addu subu and or subu slt lui or slt
b b
24010005 24220007 00411821 00622023
00832824 00A43025 00063823 00E6402A
3C091234 01285025 00C7582A
00000000 01 00000005
00000004 02 0000000c
00000008 03 00000011
0000000c 04 00000005
00000010 05 00000001
00000014 06 00000005
00000018 07 fffffffb
0000001c 08 00000001
00000020 09 12340000
00000024 0a 12340001
00000028 0b 00000000

// register 0 writes vanish, reads give zero
7 5
24000009 24010003 00210021 00011021
3C03ABCD 2464FFFF 00002825
00000004 01 00000003
0000000c 02 00000003
00000010 03 abcd0000
00000014 04 abccffff
00000018 05 00000000

// beq taken, bne not taken, bne taken, beq not taken
e 6
24010004 24020004 10220002 24030001
24040001 14220005 24060006 24C70001
14E60002 24080008 24090009 10C70002
240A000A 254B0001
00000000 01 00000004
00000004 02 00000004
00000018 06 00000006
0000001c 07 00000007
00000030 0a 0000000a
00000034 0b 0000000b

// two forward jumps
a 3
24010001 08000005 24020002 24030003
24040004 24250005 08000009 24060006
24070007 00A14021
00000000 01 00000001
00000014 05 00000006
00000024 08 00000007

/* sources.f */
logic/miniCorePkg.sv
logic/pipeBus.sv
logic/fetchUnit.sv
logic/regFile.sv
logic/decodeUnit.sv
logic/executeUnit.sv
logic/miniCore.sv
sim/wbChecker.sv
sim/miniCoreTb.sv
